//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the result
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cart_loader -f sim.f \
	&& ./obj_dir/Vtb_cart_loader > sim.log 2>&1
cat sim.log 2>/dev/null || echo "No simulation log"
grep -q "Simulation FAILED" sim.log 2>/dev/null && exit 1
grep -q "Simulation PASSED" sim.log 2>/dev/null || exit 1
exit 0

//--- sim.f
source/cart_pkg.sv
source/download_ctrl.sv
source/region_detect.sv
source/cart_quirks.sv
source/cheat_loader.sv
source/cart_loader_top.sv
testbench/tb_cart_loader.sv

//--- source/cart_loader_top.sv
// Cartridge download front end
// Download control, region detection, ID quirks and cheat loading

`default_nettype none

module cart_loader_top (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          ioctl_download,
	input  wire [cart_pkg::INDEX_W-1:0]   ioctl_index,
	input  wire                          ioctl_wr,
	input  wire [cart_pkg::ADDR_W-1:0]    ioctl_addr,
	input  wire [cart_pkg::DATA_W-1:0]    ioctl_data,
	output wire                          ioctl_wait,
	output wire                          rom_wr,
	input  wire                          rom_wrack,
	output wire [cart_pkg::ADDR_W-1:0]    rom_size,
	input  var  cart_pkg::region_mode_e   region_mode,
	input  var  cart_pkg::region_prio_e   region_prio,
	output cart_pkg::region_e             region_req,
	output wire                          region_set,
	output cart_pkg::quirk_e              quirk,
	output wire                          gun_type,
	output wire [cart_pkg::DELAY_W-1:0]   gun_delay,
	output wire [cart_pkg::CODE_W-1:0]    gg_code,
	output wire                          gg_valid,
	output wire                          gg_reset
);

	wire cart_download;
	wire cart_wr;
	wire code_wr;

	download_ctrl u_download_ctrl (
		.clk_sys, .RESET, .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr,
		.rom_wrack, .cart_download, .cart_wr, .code_wr, .rom_wr, .ioctl_wait, .rom_size
	);

	region_detect u_region_detect (
		.clk_sys, .RESET, .cart_download, .cart_wr, .ioctl_addr, .ioctl_data,
		.ioctl_index, .region_mode, .region_prio, .region_req, .region_set
	);

	cart_quirks u_cart_quirks (
		.clk_sys, .RESET, .cart_download, .cart_wr, .ioctl_addr, .ioctl_data,
		.quirk, .gun_type, .gun_delay
	);

	cheat_loader u_cheat_loader (
		.clk_sys, .RESET, .code_wr, .ioctl_addr, .ioctl_data,
		.gg_code, .gg_valid, .gg_reset
	);

endmodule

`default_nettype wire

//--- source/cart_pkg.sv
// Shared widths and header byte addresses for the cartridge loader
// Default light-gun sensor delay
// Region, region mode, priority and compatibility quirk enums

`default_nettype none

package cart_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////
	localparam int ADDR_W  = 25;   // Loader byte address
	localparam int DATA_W  = 16;   // Loader word
	localparam int INDEX_W = 8;
	localparam int CODE_W  = 128;  // Cheat code, valid bit kept apart
	localparam int ID_W    = 64;   // 8 ASCII characters
	localparam int DELAY_W = 8;

	////////////////////////////////////////////////////////////
	// Cartridge header layout
	////////////////////////////////////////////////////////////
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [ADDR_W-1:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [ADDR_W-1:0] HDR_END_ADDR     = 25'h200; // Header fully loaded
	localparam logic [ADDR_W-1:0] ID_FIRST_ADDR    = 25'h182;
	localparam logic [ADDR_W-1:0] ID_CHECK_ADDR    = 25'h18C; // ID complete by now

	localparam logic [DELAY_W-1:0] GUN_DELAY_DEFAULT = 8'd44;

	// Console region as seen by the system core
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		RMODE_HEADER   = 2'd0,
		RMODE_FILE_EXT = 2'd1,  // Region from index bits 7:6
		RMODE_DISABLED = 2'd2
	} region_mode_e;

	// Lookup order when several header flags are set
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_e;

	typedef enum logic [3:0] {
		QUIRK_NONE   = 4'd0,
		QUIRK_SRAM   = 4'd1,
		QUIRK_SRAM00 = 4'd2,
		QUIRK_EEPROM = 4'd3,
		QUIRK_NORAM  = 4'd4,
		QUIRK_FIFO   = 4'd5,
		QUIRK_PIER   = 4'd6,
		QUIRK_SVP    = 4'd7,
		QUIRK_FMBUSY = 4'd8,
		QUIRK_SCHAN  = 4'd9
	} quirk_e;

endpackage

`default_nettype wire

//--- source/cart_quirks.sv
// Cartridge ID assembly from the header words
// ID lookup for compatibility quirks and light-gun type and delay

`default_nettype none

module cart_quirks (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          cart_download,
	input  wire                          cart_wr,
	input  wire [cart_pkg::ADDR_W-1:0]    ioctl_addr,
	input  wire [cart_pkg::DATA_W-1:0]    ioctl_data,
	output cart_pkg::quirk_e              quirk,
	output logic                         gun_type,
	output logic [cart_pkg::DELAY_W-1:0]  gun_delay
);

	import cart_pkg::*;

	logic [ID_W-1:0] cart_id;
	logic            old_download;
	logic [15:0]     data_sw;

	assign data_sw = {ioctl_data[7:0], ioctl_data[15:8]};  // Byte swapped word

	// Priority table, first match wins
	function automatic quirk_e lookup_quirk(input logic [ID_W-1:0] id);
		if (id == "T-081276")      lookup_quirk = QUIRK_SRAM;    // NFL QB Club
		else if (id == "G-4060  ") lookup_quirk = QUIRK_EEPROM;  // Wonder Boy
		else if (id == "T-113016") lookup_quirk = QUIRK_NORAM;
		else if (id == "T-89016 ") lookup_quirk = QUIRK_FIFO;
		else if (id == "T-574023") lookup_quirk = QUIRK_PIER;
		else if (id == "MK-1229 ") lookup_quirk = QUIRK_SVP;     // Virtua Racing
		else if (id == "T-35036 ") lookup_quirk = QUIRK_FMBUSY;
		else if (id == " GM 0000") lookup_quirk = QUIRK_SRAM00;
		else                       lookup_quirk = QUIRK_NONE;
	endfunction

	////////////////////////////////////////////////////////////
	// ID capture
	////////////////////////////////////////////////////////////
	// Header text starts at the odd byte of 'h182, big-endian
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (ioctl_addr == ID_FIRST_ADDR)
				cart_id[63:56] <= ioctl_data[15:8];
			if (ioctl_addr == ID_FIRST_ADDR + 25'd2)
				cart_id[55:40] <= data_sw;
			if (ioctl_addr == ID_FIRST_ADDR + 25'd4)
				cart_id[39:24] <= data_sw;
			if (ioctl_addr == ID_FIRST_ADDR + 25'd6)
				cart_id[23:8] <= data_sw;
			if (ioctl_addr == ID_FIRST_ADDR + 25'd8)
				cart_id[7:0] <= ioctl_data[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirk        <= QUIRK_NONE;
			gun_type     <= 1'b0;
			gun_delay    <= GUN_DELAY_DEFAULT;
			old_download <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (~old_download & cart_download)
				quirk <= QUIRK_NONE;  // Fresh cartridge

			if (cart_wr && ioctl_addr == ID_CHECK_ADDR) begin
				quirk <= lookup_quirk(cart_id);
				if (cart_id == "T-95096-") begin  // Lethal Enforcers
					gun_type  <= 1'b1;
					gun_delay <= 8'd52;
				end else if (cart_id == "MK-1533 ") begin
					gun_type  <= 1'b0;
					gun_delay <= 8'd100;
				end else begin
					gun_type  <= 1'b0;
					gun_delay <= GUN_DELAY_DEFAULT;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cheat_loader.sv
// Cheat code assembly, eight 16-bit words per 128-bit code
// Per-code valid pulse and code list reset

`default_nettype none

module cheat_loader (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        code_wr,
	input  wire [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire [cart_pkg::DATA_W-1:0]  ioctl_data,
	output logic [cart_pkg::CODE_W-1:0] gg_code,
	output logic                       gg_valid,
	output logic                       gg_reset
);

	// First word of the file clears the stored list
	assign gg_reset = code_wr && (ioctl_addr == '0);

	// Layout {flags, address, compare, replace}, 32 bits each
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code[111:96]  <= ioctl_data;  // Flags low
				4'd2:  gg_code[127:112] <= ioctl_data;
				4'd4:  gg_code[79:64]   <= ioctl_data;  // Address low
				4'd6:  gg_code[95:80]   <= ioctl_data;
				4'd8:  gg_code[47:32]   <= ioctl_data;  // Compare low
				4'd10: gg_code[63:48]   <= ioctl_data;
				4'd12: gg_code[15:0]    <= ioctl_data;  // Replace low
				4'd14: gg_code[31:16]   <= ioctl_data;
				default: ;
			endcase
		end
	end

	// Top of the replace field completes a code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			gg_valid <= 1'b0;
		else
			gg_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

//--- source/download_ctrl.sv
// Download type decode from the loader index
// ROM write toggle handshake with loader back-pressure
// ROM size capture at the end of a cartridge download

`default_nettype none

module download_ctrl (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        ioctl_download,
	input  wire [cart_pkg::INDEX_W-1:0] ioctl_index,
	input  wire                        ioctl_wr,
	input  wire [cart_pkg::ADDR_W-1:0]  ioctl_addr,
	input  wire                        rom_wrack,
	output logic                       cart_download,
	output logic                       cart_wr,
	output logic                       code_wr,
	output logic                       rom_wr,
	output logic                       ioctl_wait,
	output logic [cart_pkg::ADDR_W-1:0] rom_size
);

	logic code_index;
	logic old_download;

	assign code_index    = &ioctl_index;   // All ones selects the cheat file
	assign cart_download = ioctl_download & ~code_index;
	assign cart_wr       = cart_download & ioctl_wr;
	assign code_wr       = ioctl_download & code_index & ioctl_wr;

	////////////////////////////////////////////////////////////
	// Memory write handshake
	////////////////////////////////////////////////////////////
	// One word in flight. The memory echoes rom_wr on rom_wrack once the
	// write is done, which releases the loader
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr       <= 1'b0;
			ioctl_wait   <= 1'b0;
			old_download <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_wr) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;  // New request
			end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Last address is still on the bus when the download level drops
	always_ff @(posedge clk_sys) begin
		if (old_download & ~cart_download)
			rom_size <= ioctl_addr;
	end

endmodule

`default_nettype wire

//--- source/region_detect.sv
// Region flags parsed from the cartridge header letters or digit
// Header-ready flag and region request by priority order or file index

`default_nettype none

module region_detect (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          cart_download,
	input  wire                          cart_wr,
	input  wire [cart_pkg::ADDR_W-1:0]    ioctl_addr,
	input  wire [cart_pkg::DATA_W-1:0]    ioctl_data,
	input  wire [cart_pkg::INDEX_W-1:0]   ioctl_index,
	input  var  cart_pkg::region_mode_e   region_mode,
	input  var  cart_pkg::region_prio_e   region_prio,
	output cart_pkg::region_e             region_req,
	output logic                         region_set
);

	import cart_pkg::*;

	logic       hdr_j, hdr_u, hdr_e;
	logic       cart_hdr_ready;
	logic       old_download;
	logic       old_ready;
	logic [7:0] hdr_lo, hdr_hi;
	logic [3:0] hrgn;

	assign hdr_lo = ioctl_data[7:0];
	assign hdr_hi = ioctl_data[15:8];
	assign hrgn   = ioctl_data[3:0] - 4'd7;  // Hex letter A-F to nibble A..F

	// First set flag in the chosen order, else the order's first region
	function automatic region_e pick_region(input region_prio_e prio,
		input logic j, input logic u, input logic e);
		case (prio)
			PRIO_US_EU_JP: pick_region = u ? REGION_US : e ? REGION_EU :
				j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: pick_region = e ? REGION_EU : u ? REGION_US :
				j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: pick_region = u ? REGION_US : j ? REGION_JP :
				e ? REGION_EU : REGION_US;
			default:       pick_region = j ? REGION_JP : u ? REGION_US :
				e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Header parsing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			cart_hdr_ready        <= 1'b0;
			old_download          <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (~old_download & cart_download)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			if (old_download & ~cart_download)
				cart_hdr_ready <= 1'b0;

			if (cart_wr) begin
				if (ioctl_addr == HDR_REGION_ADDR) begin
					if (hdr_lo == "J") hdr_j <= 1'b1;
					else if (hdr_lo == "U") hdr_u <= 1'b1;
					else if (hdr_lo == "E") hdr_e <= 1'b1;
					else if (hdr_lo >= "0" && hdr_lo <= "9")
						{hdr_e, hdr_u, hdr_j} <= {ioctl_data[3], ioctl_data[2], ioctl_data[0]};
					else if (hdr_lo >= "A" && hdr_lo <= "F")
						{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};
					// Second letter in the upper byte
					if (hdr_hi == "J") hdr_j <= 1'b1;
					else if (hdr_hi == "U") hdr_u <= 1'b1;
					else if (hdr_hi == "E") hdr_e <= 1'b1;
				end
				if (ioctl_addr == HDR_REGION2_ADDR) begin
					if (hdr_lo == "J") hdr_j <= 1'b1;
					else if (hdr_lo == "U") hdr_u <= 1'b1;
					else if (hdr_lo == "E") hdr_e <= 1'b1;
				end
				if (ioctl_addr == HDR_END_ADDR)
					cart_hdr_ready <= 1'b1;
			end
		end
	end

	// Region request, raised on the header-ready edge
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			region_set <= 1'b0;
			old_ready  <= 1'b0;
		end else begin
			old_ready <= cart_hdr_ready;
			if (~old_ready & cart_hdr_ready) begin
				case (region_mode)
					RMODE_HEADER: begin
						region_set <= 1'b1;
						region_req <= pick_region(region_prio, hdr_j, hdr_u, hdr_e);
					end
					RMODE_FILE_EXT: begin
						region_set <= |ioctl_index;
						region_req <= region_e'(ioctl_index[7:6]);
					end
					default: region_set <= 1'b0;
				endcase
			end
			if (old_ready & ~cart_hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_cart_loader.sv
// Testbench for the cartridge loader front end
// Clock, reset and a random-latency ROM acknowledge model
// Directed tests for handshake, region, quirks and cheat codes
// Compare tasks and pass/fail reporting

`default_nettype none

module tb_cart_loader;

	import cart_pkg::*;

	logic                 clk_sys;
	logic                 RESET;
	logic                 ioctl_download;
	logic [INDEX_W-1:0]   ioctl_index;
	logic                 ioctl_wr;
	logic [ADDR_W-1:0]    ioctl_addr;
	logic [DATA_W-1:0]    ioctl_data;
	logic                 rom_wrack = 1'b0;
	region_mode_e         region_mode;
	region_prio_e         region_prio;

	wire                  ioctl_wait;
	wire                  rom_wr;
	wire [ADDR_W-1:0]     rom_size;
	region_e              region_req;
	wire                  region_set;
	quirk_e               quirk;
	wire                  gun_type;
	wire [DELAY_W-1:0]    gun_delay;
	wire [CODE_W-1:0]     gg_code;
	wire                  gg_valid;
	wire                  gg_reset;

	int    seed = 51606;
	int    mem_delay;
	int    valid_count = 0;
	int    reset_count = 0;
	string test_name = "reset";

	cart_loader_top UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ROM memory answers each toggle after 1 to 4 cycles
	always begin
		@(posedge clk_sys);
		if (!RESET && rom_wr != rom_wrack) begin
			mem_delay = 1 + ({$random(seed)} % 4);
			repeat (mem_delay - 1) @(posedge clk_sys);
			rom_wrack <= rom_wr;
		end
	end

	always @(negedge clk_sys) begin
		if (gg_valid) valid_count <= valid_count + 1;
		if (gg_reset) reset_count <= reset_count + 1;  // Combinational, seen mid-strobe
	end

	////////////////////////////////////////////////////////////
	// Reporting and compare tasks
	////////////////////////////////////////////////////////////
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic value_check(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] %s: expected %0h, actual %0h",
				test_name, what, exp, act));
	endtask

	task automatic region_check(input region_e exp, input region_e act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] region_req: expected %s, actual %s",
				test_name, exp.name(), act.name()));
	endtask

	task automatic quirk_check(input quirk_e exp, input quirk_e act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] quirk: expected %s, actual %s",
				test_name, exp.name(), act.name()));
	endtask

	task automatic code_check(input logic [CODE_W-1:0] exp, input logic [CODE_W-1:0] act);
		if (act !== exp)
			fail_now($sformatf("** Error [%s] gg_code: expected %032h, actual %032h",
				test_name, exp, act));
	endtask

	////////////////////////////////////////////////////////////
	// Loader bus tasks
	////////////////////////////////////////////////////////////
	// Level is settled before the first word is sent
	task automatic start_download(input logic [INDEX_W-1:0] index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		@(negedge clk_sys);
	endtask

	// rom_size is latched on the edge that sees the level drop
	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// One strobe, then for cartridge words the full toggle handshake
	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic is_cart;
		logic exp_wr;
		int   n;
		is_cart = ioctl_download && !(&ioctl_index);
		exp_wr  = ~rom_wr;
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_data <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		if (is_cart) begin
			value_check("ioctl_wait after strobe", 32'd1, ioctl_wait);
			value_check("rom_wr toggle", exp_wr, rom_wr);
			n = 0;
			while (ioctl_wait) begin
				@(negedge clk_sys);
				n++;
				if (n > 20)
					fail_now($sformatf("[%s] ioctl_wait never fell after a ROM write",
						test_name));
			end
			value_check("rom_wr after ack", exp_wr, rom_wr);
		end
	endtask

	task automatic wait_region(input logic level);
		int n;
		n = 0;
		while (region_set !== level) begin
			@(negedge clk_sys);
			n++;
			if (n > 50)
				fail_now($sformatf("[%s] region_set did not reach %0b in time",
					test_name, level));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic rom_handshake_test();
		test_name = "rom_handshake";
		start_download(8'h00);
		for (int k = 0; k < 5; k++)
			write_word(ADDR_W'(2 * k), DATA_W'($random(seed)));
		end_download();
		value_check("rom_size", 32'd8, rom_size);
	endtask

	task automatic region_case(input string name, input region_mode_e mode,
		input region_prio_e prio, input logic [7:0] index, input logic [15:0] w_1f0,
		input logic [15:0] w_1f2, input logic exp_set, input region_e exp_region);
		test_name = name;
		@(posedge clk_sys);
		region_mode <= mode;
		region_prio <= prio;
		start_download(index);
		write_word(HDR_REGION_ADDR, w_1f0);
		write_word(HDR_REGION2_ADDR, w_1f2);
		write_word(HDR_END_ADDR, 16'h0000);
		if (exp_set) begin
			wait_region(1'b1);
			region_check(exp_region, region_req);
		end else begin
			repeat (4) @(negedge clk_sys);
			value_check("region_set stays low", 32'd0, region_set);
		end
		end_download();
		wait_region(1'b0);  // Cleared once the header flag drops
	endtask

	// ID words as stored in the header, bytes swapped within each word
	task automatic quirk_case(input string name, input logic [ID_W-1:0] id,
		input quirk_e exp_q, input logic exp_gun, input logic [DELAY_W-1:0] exp_delay);
		test_name = name;
		start_download(8'h00);
		write_word(ID_FIRST_ADDR, {id[63:56], 8'h20});
		write_word(ID_FIRST_ADDR + 25'd2, {id[47:40], id[55:48]});
		write_word(ID_FIRST_ADDR + 25'd4, {id[31:24], id[39:32]});
		write_word(ID_FIRST_ADDR + 25'd6, {id[15:8], id[23:16]});
		write_word(ID_FIRST_ADDR + 25'd8, {8'h20, id[7:0]});
		write_word(ID_CHECK_ADDR, 16'h2020);
		quirk_check(exp_q, quirk);
		value_check("gun_type", exp_gun, gun_type);
		value_check("gun_delay", exp_delay, gun_delay);
		end_download();
	endtask

	task automatic quirk_clear_test();
		test_name = "quirk_clear";
		start_download(8'h00);
		@(posedge clk_sys);
		@(negedge clk_sys);
		quirk_check(QUIRK_NONE, quirk);
		end_download();
	endtask

	// Word k sits at offset 2k; fields {flags, address, compare, replace}
	task automatic load_cheat(input logic [ADDR_W-1:0] base, input logic [127:0] words);
		logic [CODE_W-1:0] exp_code;
		exp_code = {words[31:16], words[15:0], words[63:48], words[47:32],
			words[95:80], words[79:64], words[127:112], words[111:96]};
		for (int k = 0; k < 8; k++)
			write_word(base + ADDR_W'(2 * k), words[16 * k +: 16]);
		value_check("gg_valid", 32'd1, gg_valid);
		code_check(exp_code, gg_code);
	endtask

	task automatic cheat_test();
		int v0;
		int r0;
		test_name = "cheat_codes";
		v0 = valid_count;
		r0 = reset_count;
		start_download(8'hFF);
		load_cheat(25'd0, {$random(seed), $random(seed), $random(seed), $random(seed)});
		load_cheat(25'd16, {$random(seed), $random(seed), $random(seed), $random(seed)});
		end_download();
		value_check("gg_valid pulses", 32'd2, valid_count - v0);
		value_check("gg_reset pulses", 32'd1, reset_count - r0);
	endtask

	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		region_mode    = RMODE_HEADER;
		region_prio    = PRIO_US_EU_JP;
		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;

		rom_handshake_test();
		region_case("letter_us", RMODE_HEADER, PRIO_US_EU_JP, 8'h00,
			16'h2055, 16'h2045, 1'b1, REGION_US);
		region_case("letter_eu", RMODE_HEADER, PRIO_EU_US_JP, 8'h00,
			16'h2055, 16'h2045, 1'b1, REGION_EU);
		region_case("digit_8", RMODE_HEADER, PRIO_JP_US_EU, 8'h00,
			16'h2038, 16'h2020, 1'b1, REGION_EU);
		region_case("no_region", RMODE_HEADER, PRIO_JP_US_EU, 8'h00,
			16'h2020, 16'h2020, 1'b1, REGION_JP);
		region_case("disabled", RMODE_DISABLED, PRIO_US_EU_JP, 8'h00,
			16'h2055, 16'h2020, 1'b0, REGION_JP);
		region_case("file_ext", RMODE_FILE_EXT, PRIO_US_EU_JP, 8'h80,
			16'h2055, 16'h2020, 1'b1, REGION_EU);

		quirk_case("quirk_fifo", "T-89016 ", QUIRK_FIFO, 1'b0, 8'd44);
		quirk_clear_test();
		quirk_case("gun_lethal", "T-95096-", QUIRK_NONE, 1'b1, 8'd52);
		quirk_case("unknown_id", "ABCDEFGH", QUIRK_NONE, 1'b0, 8'd44);

		cheat_test();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
